//--- verif/fir_input_vectors.txt
// fir input vectors, hex words, one record per line
// 1 = run start, 2 h0..h10 = coefficients, 3 n = data length
// 4 x y = input sample x and expected output y, 6 k v = tap k write issued mid-run
// f = end of records
1
2 1 2 3 4 5 6 7 8 9 a b
3 d
6 0 64
4 1 1
4 ffffffff 1
4 2 3
4 0 5
4 3 a
4 fffffffe d
4 1 11
4 4 19
4 fffffffd 1e
4 5 28
4 2 34
4 ffffffff 33
4 6 4f
1
2 2 ffffffff fffffffd 0 0 0 0 0 0 0 7
3 8
4 5 a
4 40000000 7ffffffb
4 fffffffc bfffffe9
4 7 40000012
4 7fffffff 3
4 1 7fffffee
4 fffffffa 7ffffff6
4 3 9
f

//--- verilog.f
common/fir_pkg.sv
rtl/fir_cfg_regs.sv
lite/fir_lite_slave.sv
datapath/fir_sample_ring.sv
datapath/fir_mac_engine.sv
rtl/fir_top.sv
verif/fir_clk_gen.sv
verif/fir_tb.sv

//--- verif/fir_tb.sv
/* fir filter testbench */
`timescale 1ns/1ps
module fir_tb;
    import fir_pkg::*;

    localparam int    MAX_RUNS       = 2;
    localparam int    MAX_SMP        = 32;
    localparam int    MEM_WORDS      = 256;
    localparam addr_t ADDR_UNMAPPED  = 12'h00c;
    localparam addr_t ADDR_PAST_TAPS = 12'h04c;

    logic    axis_clk;
    logic    axis_rst_n;
    logic    awvalid;
    logic    awready;
    addr_t   awaddr;
    logic    wvalid;
    logic    wready;
    sample_t wdata;
    logic    arvalid;
    logic    arready;
    addr_t   araddr;
    logic    rvalid;
    logic    rready;
    sample_t rdata;
    logic    ss_tvalid;
    logic    ss_tready;
    sample_t ss_tdata;
    logic    sm_tvalid;
    logic    sm_tready;
    sample_t sm_tdata;
    logic    sm_tlast;

    // vectors per run section
    logic [31:0] vec_mem [MEM_WORDS];
    sample_t     coef_v [MAX_RUNS][NUM_TAPS];
    sample_t     len_v [MAX_RUNS];
    sample_t     x_v [MAX_RUNS][MAX_SMP];
    sample_t     y_v [MAX_RUNS][MAX_SMP];
    int          n_smp [MAX_RUNS];
    logic        lock_en [MAX_RUNS];
    int          lock_idx [MAX_RUNS];
    sample_t     lock_val [MAX_RUNS];

    int   num_runs = 0;
    int   cycle_cnt = 0;
    int   cycle_limit = 0;
    int   value_errs = 0;
    int   proto_errs = 0;
    int   out_seen = 0;
    int   seed = 32'h1c18;
    int   rnd_init;
    logic collecting = 1'b0;

    fir_clk_gen clk_gen_i (
        .axis_clk(axis_clk),
        .axis_rst_n(axis_rst_n)
    );

    fir_top fir_top_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .ss_tvalid(ss_tvalid), .ss_tready(ss_tready), .ss_tdata(ss_tdata),
        .sm_tvalid(sm_tvalid), .sm_tready(sm_tready), .sm_tdata(sm_tdata),
        .sm_tlast(sm_tlast)
    );

    task automatic print_counts();
        $display("errors: %0d value mismatches, %0d protocol failures", value_errs, proto_errs);
    endtask

    task automatic check_word(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // field by field with the reserved bits as one field
    task automatic check_ctrl(input string name, input cfg_word_u got, input cfg_word_u exp);
        if (got.ctrl.ap_start !== exp.ctrl.ap_start) begin
            value_errs++;
            $display("[ERROR] %s.ap_start got %h expected %h", name,
                     got.ctrl.ap_start, exp.ctrl.ap_start);
        end
        if (got.ctrl.ap_done !== exp.ctrl.ap_done) begin
            value_errs++;
            $display("[ERROR] %s.ap_done got %h expected %h", name,
                     got.ctrl.ap_done, exp.ctrl.ap_done);
        end
        if (got.ctrl.ap_idle !== exp.ctrl.ap_idle) begin
            value_errs++;
            $display("[ERROR] %s.ap_idle got %h expected %h", name,
                     got.ctrl.ap_idle, exp.ctrl.ap_idle);
        end
        if (got.ctrl.reserved !== exp.ctrl.reserved) begin
            value_errs++;
            $display("[ERROR] %s.reserved got %h expected %h", name,
                     got.ctrl.reserved, exp.ctrl.reserved);
        end
    endtask

    function automatic cfg_word_u make_ctrl(input logic idle, input logic done, input logic start);
        cfg_word_u w;
        w.raw = '0;
        w.ctrl.ap_idle  = idle;
        w.ctrl.ap_done  = done;
        w.ctrl.ap_start = start;
        return w;
    endfunction

    // aw and w presented together and ready sampled at the falling edge
    task automatic lite_write(input addr_t addr, input sample_t data);
        @(posedge axis_clk);
        #1;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        @(negedge axis_clk);
        while (!(awready && wready)) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic lite_read(input addr_t addr, output sample_t data);
        @(posedge axis_clk);
        #1;
        arvalid = 1'b1;
        araddr  = addr;
        rready  = 1'b1;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
        arvalid = 1'b0;
        @(negedge axis_clk);
        while (!rvalid) @(negedge axis_clk);
        data = rdata;
        @(posedge axis_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic read_ctrl(output cfg_word_u ctrl);
        sample_t rd;
        lite_read(ADDR_CTRL, rd);
        ctrl.raw = rd;
    endtask

    // tag 1 opens a run, 2 carries the taps, 3 the length, 4 a sample and its result,
    // 6 a mid-run tap write and f ends the records
    task automatic load_vectors();
        int p;
        int run;
        int total;
        logic [31:0] tag;
        p = 0;
        run = -1;
        total = 0;
        $readmemh("verif/fir_input_vectors.txt", vec_mem);
        while (p < MEM_WORDS && vec_mem[p] !== 32'hf) begin
            tag = vec_mem[p];
            if (tag === 32'h1 && run < MAX_RUNS - 1) begin
                run++;
                n_smp[run] = 0;
                lock_en[run] = 1'b0;
                p += 1;
            end else if (tag === 32'h2 && run >= 0) begin
                for (int k = 0; k < NUM_TAPS; k++) begin
                    coef_v[run][k] = vec_mem[p + 1 + k];
                end
                p += 1 + NUM_TAPS;
            end else if (tag === 32'h3 && run >= 0) begin
                len_v[run] = vec_mem[p + 1];
                p += 2;
            end else if (tag === 32'h4 && run >= 0 && n_smp[run] < MAX_SMP) begin
                x_v[run][n_smp[run]] = vec_mem[p + 1];
                y_v[run][n_smp[run]] = vec_mem[p + 2];
                n_smp[run]++;
                total++;
                p += 3;
            end else if (tag === 32'h6 && run >= 0) begin
                lock_en[run]  = 1'b1;
                lock_idx[run] = int'(vec_mem[p + 1]);
                lock_val[run] = vec_mem[p + 2];
                p += 3;
            end else begin
                proto_errs++;
                $display("malformed record at word %0d of the vector file", p);
                p = MEM_WORDS;
            end
        end
        num_runs = run + 1;
        if (num_runs == 0) begin
            proto_errs++;
            $display("the vector file holds no run section");
        end
        // worst case per sample plus register traffic
        cycle_limit = total * 40 + 500;
    endtask

    task automatic feed_samples(input int run);
        @(posedge axis_clk);
        #1;
        for (int i = 0; i < n_smp[run]; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = x_v[run][i];
            @(negedge axis_clk);
            while (!ss_tready) @(negedge axis_clk);
            @(posedge axis_clk);
            #1;
        end
        ss_tvalid = 1'b0;
    endtask

    // random stalls on sm_tready about one cycle in four
    task automatic collect_outputs(input int run);
        sample_t held;
        logic    stalled;
        int      rnd;
        out_seen = 0;
        stalled  = 1'b0;
        held     = '0;
        while (out_seen < n_smp[run]) begin
            @(posedge axis_clk);
            #1;
            rnd = $urandom % 4;
            sm_tready = (rnd != 0);
            @(negedge axis_clk);
            if (stalled && !sm_tvalid) begin
                proto_errs++;
                $display("sm_tvalid dropped before output %0d was taken", out_seen + 1);
            end else if (stalled) begin
                check_word("sm_tdata while stalled", sm_tdata, held);
            end
            if (sm_tvalid && sm_tready) begin
                check_word($sformatf("sm_tdata output %0d", out_seen + 1), sm_tdata,
                           y_v[run][out_seen]);
                if (sm_tlast !== (out_seen == int'(len_v[run]) - 1)) begin
                    proto_errs++;
                    $display("sm_tlast is %b on output %0d of %0d", sm_tlast,
                             out_seen + 1, len_v[run]);
                end
                out_seen++;
            end
            stalled = sm_tvalid && !sm_tready;
            held    = sm_tdata;
        end
        @(posedge axis_clk);
        #1;
        sm_tready  = 1'b1;
        collecting = 1'b0;
    endtask

    task automatic run_test(input int r);
        sample_t   rd;
        cfg_word_u ctrl;
        if (int'(len_v[r]) != n_smp[r]) begin
            proto_errs++;
            $display("run %0d length %0d does not match its %0d samples", r, len_v[r], n_smp[r]);
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            lite_write(ADDR_TAP_BASE + addr_t'(4 * k), coef_v[r][k]);
        end
        lite_write(ADDR_LEN, len_v[r]);
        for (int k = 0; k < NUM_TAPS; k++) begin
            lite_read(ADDR_TAP_BASE + addr_t'(4 * k), rd);
            check_word($sformatf("tap %0d readback", k), rd, coef_v[r][k]);
        end
        lite_read(ADDR_LEN, rd);
        check_word("data_length readback", rd, len_v[r]);
        lite_read(ADDR_UNMAPPED, rd);
        check_word("unmapped 0x00c readback", rd, '0);
        lite_read(ADDR_PAST_TAPS, rd);
        check_word("unmapped 0x04c readback", rd, '0);

        lite_write(ADDR_CTRL, 32'h1);
        collecting = 1'b1;
        fork
            feed_samples(r);
            collect_outputs(r);
            begin
                // busy with start and done cleared and then a tap write that must not land
                read_ctrl(ctrl);
                check_ctrl("ctrl during run", ctrl, make_ctrl(1'b0, 1'b0, 1'b0));
                if (lock_en[r]) begin
                    lite_write(ADDR_TAP_BASE + addr_t'(4 * lock_idx[r]), lock_val[r]);
                end
            end
        join

        // done is readable the cycle after run_done
        read_ctrl(ctrl);
        check_ctrl("ctrl after run", ctrl, make_ctrl(1'b1, 1'b1, 1'b0));
        if (lock_en[r]) begin
            lite_read(ADDR_TAP_BASE + addr_t'(4 * lock_idx[r]), rd);
            check_word("tap after locked write", rd, coef_v[r][lock_idx[r]]);
        end
    endtask

    // outputs outside a collection window are strays
    always @(negedge axis_clk) begin
        if (axis_rst_n && !collecting && sm_tvalid && sm_tready) begin
            proto_errs++;
            $display("stray output %h on the stream outside a run", sm_tdata);
        end
    end

    always @(posedge axis_clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            proto_errs++;
            $display("timeout after %0d cycles with %0d outputs received in the current run",
                     cycle_cnt, out_seen);
            print_counts();
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        cfg_word_u ctrl;
        awvalid   = 1'b0;
        awaddr    = '0;
        wvalid    = 1'b0;
        wdata     = '0;
        arvalid   = 1'b0;
        araddr    = '0;
        rready    = 1'b0;
        ss_tvalid = 1'b0;
        ss_tdata  = '0;
        sm_tready = 1'b1;
        rnd_init  = $urandom(seed);
        load_vectors();
        wait (axis_rst_n === 1'b1);

        // only ap_idle after reset
        read_ctrl(ctrl);
        check_ctrl("ctrl after reset", ctrl, make_ctrl(1'b1, 1'b0, 1'b0));

        for (int r = 0; r < num_runs; r++) begin
            run_test(r);
        end

        print_counts();
        if (value_errs == 0 && proto_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

//--- verif/fir_clk_gen.sv
/* testbench clock and reset */
`timescale 1ns/1ps
module fir_clk_gen (
    output logic axis_clk,
    output logic axis_rst_n
);
    // 8 ns period
    initial begin
        axis_clk = 1'b0;
        forever #4 axis_clk = ~axis_clk;
    end

    // low for 4 cycles, released 1 ns after the edge
    initial begin
        axis_rst_n = 1'b0;
        repeat (4) @(posedge axis_clk);
        #1 axis_rst_n = 1'b1;
    end

endmodule

//--- rtl/fir_top.sv
/* fir filter top level */
`timescale 1ns/1ps
module fir_top (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    input  logic             awvalid,
    output logic             awready,
    input  fir_pkg::addr_t   awaddr,
    input  logic             wvalid,
    output logic             wready,
    input  fir_pkg::sample_t wdata,
    input  logic             arvalid,
    output logic             arready,
    input  fir_pkg::addr_t   araddr,
    output logic             rvalid,
    input  logic             rready,
    output fir_pkg::sample_t rdata,
    input  logic             ss_tvalid,
    output logic             ss_tready,
    input  fir_pkg::sample_t ss_tdata,
    output logic             sm_tvalid,
    input  logic             sm_tready,
    output fir_pkg::sample_t sm_tdata,
    output logic             sm_tlast
);
    import fir_pkg::*;

    // register access between lite slave and config block
    logic     reg_wr;
    logic     reg_rd;
    addr_t    reg_addr;
    sample_t  reg_wdata;
    sample_t  reg_rdata;

    // config to engine
    logic     start;
    logic     run_done;
    sample_t  data_len;
    tap_idx_t coef_idx;
    sample_t  coef;

    // engine to history ring
    logic     ring_clr;
    logic     ring_push;
    sample_t  push_data;
    tap_idx_t hist_idx;
    sample_t  hist_sample;

    fir_lite_slave lite_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .awvalid(awvalid), .awready(awready), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata),
        .arvalid(arvalid), .arready(arready), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rdata(rdata),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
    );

    fir_cfg_regs cfg_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
        .reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
        .start(start), .data_len(data_len),
        .coef_idx(coef_idx), .coef(coef), .run_done(run_done)
    );

    fir_mac_engine mac_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .start(start), .data_len(data_len), .run_done(run_done),
        .ss_tvalid(ss_tvalid), .ss_tready(ss_tready), .ss_tdata(ss_tdata),
        .sm_tvalid(sm_tvalid), .sm_tready(sm_tready), .sm_tdata(sm_tdata),
        .sm_tlast(sm_tlast), .coef_idx(coef_idx), .coef(coef),
        .ring_clr(ring_clr), .ring_push(ring_push), .push_data(push_data),
        .hist_idx(hist_idx), .hist_sample(hist_sample)
    );

    fir_sample_ring ring_i (
        .axis_clk(axis_clk), .axis_rst_n(axis_rst_n),
        .ring_clr(ring_clr), .ring_push(ring_push), .push_data(push_data),
        .hist_idx(hist_idx), .hist_sample(hist_sample)
    );

endmodule

//--- datapath/fir_mac_engine.sv
/* fir multiply-accumulate engine */
`timescale 1ns/1ps
module fir_mac_engine (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              start,
    input  fir_pkg::sample_t  data_len,
    output logic              run_done,
    input  logic              ss_tvalid,
    output logic              ss_tready,
    input  fir_pkg::sample_t  ss_tdata,
    output logic              sm_tvalid,
    input  logic              sm_tready,
    output fir_pkg::sample_t  sm_tdata,
    output logic              sm_tlast,
    output fir_pkg::tap_idx_t coef_idx,
    input  fir_pkg::sample_t  coef,
    output logic              ring_clr,
    output logic              ring_push,
    output fir_pkg::sample_t  push_data,
    output fir_pkg::tap_idx_t hist_idx,
    input  fir_pkg::sample_t  hist_sample
);
    import fir_pkg::*;

    logic              run_active;
    logic              acc_busy;
    tap_idx_t          tap_cnt;
    sample_t           acc;
    sample_t           acc_in;
    sample_t           product;
    sample_t           mac_sum;
    logic [DATA_W-1:0] in_cnt;
    logic [DATA_W-1:0] out_cnt;
    logic              take_in;
    logic              take_out;
    logic              last_step;
    logic              out_free;
    logic              load_out;

    assign take_in  = ss_tvalid && ss_tready;
    assign take_out = sm_tvalid && sm_tready;

    // no intake while accumulating or once data_len samples are in
    assign ss_tready = run_active && !acc_busy && (in_cnt < $unsigned(data_len));

    // history cleared on start, each accepted sample pushed
    assign ring_clr  = start;
    assign ring_push = take_in;
    assign push_data = ss_tdata;

    // one tap per cycle, same index into taps and history
    assign coef_idx = tap_cnt;
    assign hist_idx = tap_cnt;

    // the single multiplier and adder, 32-bit wrap
    assign product = coef * hist_sample;
    assign acc_in  = (tap_cnt == '0) ? '0 : acc;
    assign mac_sum = acc_in + product;

    // output register free or emptying this cycle
    assign last_step = acc_busy && (tap_cnt == tap_idx_t'(LAST_TAP));
    assign out_free  = !sm_tvalid || sm_tready;
    assign load_out  = last_step && out_free;

    // tap sequencer, parks at the final step under back-pressure
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            acc_busy <= 1'b0;
            tap_cnt  <= '0;
        end else if (start) begin
            acc_busy <= 1'b0;
            tap_cnt  <= '0;
        end else if (take_in) begin
            acc_busy <= 1'b1;
            tap_cnt  <= '0;
        end else if (load_out) begin
            acc_busy <= 1'b0;
            tap_cnt  <= '0;
        end else if (acc_busy && !last_step) begin
            tap_cnt <= tap_cnt + 1'b1;
        end
    end

    // partial sum of taps so far
    always_ff @(posedge axis_clk) begin
        if (acc_busy && !last_step) begin
            acc <= mac_sum;
        end
    end

    // output valid and last, a new result beats a draining one
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else if (start) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else if (load_out) begin
            sm_tvalid <= 1'b1;
            // in_cnt already counts the sample behind this result
            sm_tlast  <= (in_cnt == $unsigned(data_len));
        end else if (take_out) begin
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (load_out) begin
            sm_tdata <= mac_sum;
        end
    end

    // run bookkeeping
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            run_active <= 1'b0;
            run_done   <= 1'b0;
            in_cnt     <= '0;
            out_cnt    <= '0;
        end else begin
            run_done <= 1'b0;
            if (start) begin
                run_active <= 1'b1;
                in_cnt     <= '0;
                out_cnt    <= '0;
            end else begin
                if (take_in) begin
                    in_cnt <= in_cnt + 1'b1;
                end
                if (take_out) begin
                    out_cnt <= out_cnt + 1'b1;
                    // final output handed over
                    if (out_cnt + 1'b1 == $unsigned(data_len)) begin
                        run_active <= 1'b0;
                        run_done   <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

//--- datapath/fir_sample_ring.sv
/* fir sample history ring */
`timescale 1ns/1ps
module fir_sample_ring (
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              ring_clr,
    input  logic              ring_push,
    input  fir_pkg::sample_t  push_data,
    input  fir_pkg::tap_idx_t hist_idx,
    output fir_pkg::sample_t  hist_sample
);
    import fir_pkg::*;

    sample_t  slots [NUM_TAPS];
    tap_idx_t wr_ptr;
    tap_idx_t newest;
    tap_idx_t rd_slot;

    // slot holding the latest sample
    assign newest = (wr_ptr == '0) ? tap_idx_t'(LAST_TAP) : wr_ptr - 1'b1;

    // step back hist_idx slots, wrapping at NUM_TAPS
    assign rd_slot = (newest >= hist_idx) ? newest - hist_idx :
                     tap_idx_t'(newest + NUM_TAPS - hist_idx);

    assign hist_sample = slots[rd_slot];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            wr_ptr <= '0;
        end else if (ring_clr) begin
            wr_ptr <= '0;
        end else if (ring_push) begin
            wr_ptr <= (wr_ptr == tap_idx_t'(LAST_TAP)) ? '0 : wr_ptr + 1'b1;
        end
    end

    // cleared history means zero samples before the run
    always_ff @(posedge axis_clk) begin
        if (ring_clr) begin
            for (int i = 0; i < NUM_TAPS; i++) begin
                slots[i] <= '0;
            end
        end else if (ring_push) begin
            slots[wr_ptr] <= push_data;
        end
    end

endmodule

//--- lite/fir_lite_slave.sv
/* axi-lite register slave */
`timescale 1ns/1ps
module fir_lite_slave (
    input  logic             axis_clk,
    input  logic             axis_rst_n,
    input  logic             awvalid,
    output logic             awready,
    input  fir_pkg::addr_t   awaddr,
    input  logic             wvalid,
    output logic             wready,
    input  fir_pkg::sample_t wdata,
    input  logic             arvalid,
    output logic             arready,
    input  fir_pkg::addr_t   araddr,
    output logic             rvalid,
    input  logic             rready,
    output fir_pkg::sample_t rdata,
    output logic             reg_wr,
    output logic             reg_rd,
    output fir_pkg::addr_t   reg_addr,
    output fir_pkg::sample_t reg_wdata,
    input  fir_pkg::sample_t reg_rdata
);
    import fir_pkg::*;

    logic [LITE_ST_W-1:0] state;
    addr_t                addr_q;
    sample_t              wdata_q;
    logic                 rd_take;
    logic                 wr_take;

    // read wins when both channels are pending
    assign rd_take = (state == LITE_IDLE) && arvalid;
    assign wr_take = (state == LITE_IDLE) && !arvalid && awvalid && wvalid;

    // address and data accepted together
    assign arready = rd_take;
    assign awready = wr_take;
    assign wready  = wr_take;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state <= LITE_IDLE;
        end else begin
            case (state)
                LITE_IDLE: begin
                    if (rd_take) begin
                        state <= LITE_RREQ;
                    end else if (wr_take) begin
                        state <= LITE_WR;
                    end
                end
                // one register access, then back
                LITE_WR: begin
                    state <= LITE_IDLE;
                end
                LITE_RREQ: begin
                    state <= LITE_RHOLD;
                end
                // wait for the master to take the data
                LITE_RHOLD: begin
                    if (rready) begin
                        state <= LITE_IDLE;
                    end
                end
                default: begin
                    state <= LITE_IDLE;
                end
            endcase
        end
    end

    // latch address and write data on the handshake
    always_ff @(posedge axis_clk) begin
        if (rd_take) begin
            addr_q <= araddr;
        end else if (wr_take) begin
            addr_q  <= awaddr;
            wdata_q <= wdata;
        end
    end

    assign reg_wr    = (state == LITE_WR);
    assign reg_rd    = (state == LITE_RREQ);
    assign reg_addr  = addr_q;
    assign reg_wdata = wdata_q;

    // readback register only moves on reg_rd, so stable during hold
    assign rvalid = (state == LITE_RHOLD);
    assign rdata  = rvalid ? reg_rdata : '0;

endmodule

//--- rtl/fir_cfg_regs.sv
/* fir configuration registers */
`timescale 1ns/1ps
module fir_cfg_regs (
    input  logic               axis_clk,
    input  logic               axis_rst_n,
    input  logic               reg_wr,
    input  logic               reg_rd,
    input  fir_pkg::addr_t     reg_addr,
    input  fir_pkg::sample_t   reg_wdata,
    output fir_pkg::sample_t   reg_rdata,
    output logic               start,
    output fir_pkg::sample_t   data_len,
    input  fir_pkg::tap_idx_t  coef_idx,
    output fir_pkg::sample_t   coef,
    input  logic               run_done
);
    import fir_pkg::*;

    cfg_word_u ctrl_q;
    cfg_word_u wr_word;
    sample_t   len_q;
    sample_t   coef_bank [NUM_TAPS];
    addr_t     tap_off;
    tap_idx_t  tap_sel;
    logic      hit_ctrl;
    logic      hit_len;
    logic      hit_tap;
    logic      cfg_wr_ok;
    sample_t   rd_mux;

    // incoming word seen through the control view
    assign wr_word = cfg_word_u'(reg_wdata);

    // address decode
    assign hit_ctrl = (reg_addr == ADDR_CTRL);
    assign hit_len  = (reg_addr == ADDR_LEN);
    assign tap_off  = reg_addr - ADDR_TAP_BASE;
    // word aligned and inside the bank
    assign hit_tap  = (reg_addr >= ADDR_TAP_BASE) && (tap_off[1:0] == 2'b00) &&
                      (tap_off[ADDR_W-1:2] < NUM_TAPS);
    assign tap_sel  = tap_off[TAP_IDX_W+1:2];

    // length and taps locked while a run is active
    assign cfg_wr_ok = reg_wr && ctrl_q.ctrl.ap_idle;

    // start pulse lasts as long as ap_start is set
    assign start    = ctrl_q.ctrl.ap_start;
    assign data_len = len_q;
    assign coef     = coef_bank[coef_idx];

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ctrl_q.raw <= CTRL_RESET;
        end else begin
            if (ctrl_q.ctrl.ap_start) begin
                // run launched, busy from here on
                ctrl_q.ctrl.ap_start <= 1'b0;
                ctrl_q.ctrl.ap_idle  <= 1'b0;
                ctrl_q.ctrl.ap_done  <= 1'b0;
            end else if (reg_wr && hit_ctrl && wr_word.ctrl.ap_start &&
                         ctrl_q.ctrl.ap_idle) begin
                ctrl_q.ctrl.ap_start <= 1'b1;
            end
            // last output gone
            if (run_done) begin
                ctrl_q.ctrl.ap_done <= 1'b1;
                ctrl_q.ctrl.ap_idle <= 1'b1;
            end
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            len_q <= '0;
        end else if (cfg_wr_ok && hit_len) begin
            len_q <= reg_wdata;
        end
    end

    // coefficient bank
    always_ff @(posedge axis_clk) begin
        if (cfg_wr_ok && hit_tap) begin
            coef_bank[tap_sel] <= reg_wdata;
        end
    end

    // readback, unmapped reads as zero
    always_comb begin
        rd_mux = '0;
        if (hit_ctrl) begin
            rd_mux = ctrl_q.raw;
        end else if (hit_len) begin
            rd_mux = len_q;
        end else if (hit_tap) begin
            rd_mux = coef_bank[tap_sel];
        end
    end

    // data one cycle after reg_rd
    always_ff @(posedge axis_clk) begin
        if (reg_rd) begin
            reg_rdata <= rd_mux;
        end
    end

endmodule

//--- common/fir_pkg.sv
/* fir filter shared definitions */
package fir_pkg;

    // bus widths
    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 12;

    // filter length and tap index range
    localparam int NUM_TAPS  = 11;
    localparam int LAST_TAP  = NUM_TAPS - 1;
    localparam int TAP_IDX_W = 4;

    // register map
    localparam logic [ADDR_W-1:0] ADDR_CTRL     = 12'h000;
    localparam logic [ADDR_W-1:0] ADDR_LEN      = 12'h010;
    localparam logic [ADDR_W-1:0] ADDR_TAP_BASE = 12'h020;

    // control word after reset with only ap_idle set
    localparam logic [DATA_W-1:0] CTRL_RESET = 32'h0000_0004;

    // lite slave states
    localparam int LITE_ST_W = 2;
    localparam logic [LITE_ST_W-1:0] LITE_IDLE  = 2'd0;
    localparam logic [LITE_ST_W-1:0] LITE_WR    = 2'd1;
    localparam logic [LITE_ST_W-1:0] LITE_RREQ  = 2'd2;
    localparam logic [LITE_ST_W-1:0] LITE_RHOLD = 2'd3;

    // sample, coefficient and result word
    typedef logic signed [DATA_W-1:0] sample_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [TAP_IDX_W-1:0] tap_idx_t;

    // block-level control bits with ap_start in bit 0
    typedef struct packed {
        logic [28:0] reserved;
        logic        ap_idle;
        logic        ap_done;
        logic        ap_start;
    } ap_ctrl_t;

    // same access word as control bits at ADDR_CTRL and as a plain number elsewhere
    typedef union packed {
        sample_t  raw;
        ap_ctrl_t ctrl;
    } cfg_word_u;

endpackage
